// File: Makefile
TOOL      := verilator
FLAGS     := --timing --assert --timescale 1ns/1ps
TOP       := tb_xcvr_status
RTL_TOP   := xcvr_status_top
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/xcvr_status_if.sv
// Synchronized transceiver status levels, resync block to link monitor
// All four signals are plain levels in the d_clk domain, no handshake
`timescale 1ns/1ps
`default_nettype none

interface xcvr_status_if;
	import xcvr_status_pkg::*;

	logic pll_locked;
	logic cdr_locked;
	logic sig_det;
	logic fifo_err;

	// Four named levels must cover the whole status vector
	if (STATUS_W != 4) begin : g_width_check
		$error("xcvr_status_if carries 4 signals, STATUS_W is %0d", STATUS_W);
	end

	// Driven by the synchronizer chains
	modport src (output pll_locked, cdr_locked, sig_det, fifo_err);

	// Read by the link monitor
	modport dst (input pll_locked, cdr_locked, sig_det, fifo_err);

endinterface

`default_nettype wire

// File: common/xcvr_status_pkg.sv
// Widths, status bit positions and link monitor state shared by the status path
// Status vector order is fixed: pll, cdr, signal detect, fifo error (bit 0 to 3)
`default_nettype none

package xcvr_status_pkg;

	// Transceiver status levels entering the design
	localparam int STATUS_W = 4;

	// Loss-of-link and FIFO error counters, saturating
	localparam int CNT_W = 8;

	// Bit positions inside the status vector
	localparam int STATUS_PLL      = 0;
	localparam int STATUS_CDR      = 1;
	localparam int STATUS_SIGDET   = 2;
	localparam int STATUS_FIFO_ERR = 3;

	// Link monitor FSM
	// WAIT is the debounce window before the link is declared up
	typedef enum logic [1:0] {
		LINK_DOWN = 2'd0,
		LINK_WAIT = 2'd1,
		LINK_UP   = 2'd2
	} link_state_e;

endpackage

`default_nettype wire

// File: resync/status_resync.sv
// Per-bit flop chains moving the transceiver status levels into d_clk
// Inputs must stay stable for more than one d_clk period or they can be missed
// INIT_VALUE 1 makes every chain power up and reset high through inversion
`timescale 1ns/1ps
`default_nettype none

module status_resync #(
	parameter int SYNC_LEN   = 3,
	parameter int INIT_VALUE = 0
) (
	input  logic                                  d_clk,
	input  logic                                  rst_n,
	input  logic [xcvr_status_pkg::STATUS_W-1:0]  status_in,
	xcvr_status_if.src                            sync_out
);
	import xcvr_status_pkg::*;

	// Chain value as seen at the outputs while in reset
	localparam logic INIT_BIT = (INIT_VALUE == 1);
	localparam logic [STATUS_W-1:0] INIT_VEC = {STATUS_W{INIT_BIT}};

	// Last stage of each chain, after output inversion
	logic [STATUS_W-1:0] sync_bits;

	// Reject chains too short for metastability and odd init values
	if (SYNC_LEN < 2) begin : g_len_check
		$error("status_resync needs SYNC_LEN >= 2, got %0d", SYNC_LEN);
	end
	if (INIT_VALUE != 0 && INIT_VALUE != 1) begin : g_init_check
		$error("status_resync needs INIT_VALUE 0 or 1, got %0d", INIT_VALUE);
	end

	for (genvar i = 0; i < STATUS_W; i++) begin : g_chain
		logic                d_in;
		logic [SYNC_LEN-1:0] chain_q;

		// Flops always reset to zero
		// inverting both ends turns that into a high reset value
		assign d_in = INIT_BIT ? ~status_in[i] : status_in[i];

		always_ff @(posedge d_clk or negedge rst_n) begin
			if (!rst_n) begin
				chain_q <= '0;
			end else begin
				// Bit 0 samples the async input
				chain_q <= {chain_q[SYNC_LEN-2:0], d_in};
			end
		end

		assign sync_bits[i] = INIT_BIT ? ~chain_q[SYNC_LEN-1] : chain_q[SYNC_LEN-1];
	end

	// Map vector positions onto the named levels
	assign sync_out.pll_locked = sync_bits[STATUS_PLL];
	assign sync_out.cdr_locked = sync_bits[STATUS_CDR];
	assign sync_out.sig_det    = sync_bits[STATUS_SIGDET];
	assign sync_out.fifo_err   = sync_bits[STATUS_FIFO_ERR];

	// The monitor must see the init value for the whole reset,
	// including the edge on which reset releases
	assert property (@(posedge d_clk) !rst_n |-> (sync_bits == INIT_VEC))
		else $error("Resync output %h differs from init value in reset", sync_bits);

endmodule

`default_nettype wire

// File: testbench/status_golden.txt
# tag op status(hex) hold(cycles) reps state(hex) link_up loss_count(hex) err_count(hex)
# ops: hold, up (wait for link_up), glitch (random drops), pulse (fifo_err), reset (clr_n low)
after_reset   hold    0   4   1    0  0  00  00
short_lock    hold    7   10  1    1  0  00  00
idle_a        hold    0   8   1    0  0  00  00
glitches      glitch  7   8   24   0  0  00  00
link_up_a     up      7   4   1    2  1  00  00
drop_sigdet   hold    3   5   1    0  0  01  00
idle_b        hold    0   8   1    0  0  01  00
link_up_b     up      7   4   1    2  1  01  00
drop_pll      hold    6   5   1    0  0  02  00
link_up_c     up      7   4   1    2  1  02  00
drop_cdr      hold    5   5   1    0  0  03  00
fifo_three    pulse   0   6   3    0  0  03  03
mid_reset     reset   0   10  1    0  0  00  00
link_up_d     up      7   4   1    2  1  00  00
drop_after    hold    3   5   1    0  0  01  00
fifo_sat      pulse   0   6   260  0  0  01  ff
fifo_level    hold    8   8   1    0  0  01  ff
final_reset   reset   0   10  1    0  0  00  00

// File: testbench/tb_xcvr_status.sv
// Testbench for xcvr_status_top, stepped through testbench/status_golden.txt
// Inputs change and outputs are sampled on the falling edge of d_clk
// Run from the project root so the golden file path resolves
`timescale 1ns/1ps
`default_nettype none

module tb_xcvr_status;
	import xcvr_status_pkg::*;

	localparam int SYNC_LEN      = 3;
	localparam int INIT_VALUE    = 0;
	localparam int STABLE_CYCLES = 16;
	// Longest wait for link up once the lock bits are high
	localparam int LINK_TIMEOUT  = SYNC_LEN + STABLE_CYCLES + 8;
	// Cycles after clr_n release before the next step
	localparam int SETTLE_CYCLES = 4;
	localparam int MAX_LINES     = 1000;

	logic                d_clk;
	logic                clr_n;
	logic [STATUS_W-1:0] xcvr_status;
	logic                link_up;
	logic [1:0]          link_state;
	logic [CNT_W-1:0]    loss_count;
	logic [CNT_W-1:0]    err_count;

	integer seed;
	int     fd;
	int     step_errs;
	int     tests_run;
	int     tests_failed;

	xcvr_status_top #(
		.SYNC_LEN      (SYNC_LEN),
		.INIT_VALUE    (INIT_VALUE),
		.STABLE_CYCLES (STABLE_CYCLES)
	) xcvr_status_top_i (
		.d_clk       (d_clk),
		.clr_n       (clr_n),
		.xcvr_status (xcvr_status),
		.link_up     (link_up),
		.link_state  (link_state),
		.loss_count  (loss_count),
		.err_count   (err_count)
	);

	// 4 ns clock
	always #2 d_clk = ~d_clk;

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge d_clk);
	endtask

	// Link must stay down on every cycle
	task automatic watch_link_down(input int n);
		for (int c = 0; c < n; c++) begin
			@(negedge d_clk);
			assert (link_up === 1'b0)
				else begin
					$display("Mismatch link_up during glitches: got %h, expected %h", link_up, 1'b0);
					step_errs++;
				end
		end
	endtask

	task automatic wait_link_up();
		int waited;
		waited = 0;
		while (link_up !== 1'b1 && waited < LINK_TIMEOUT) begin
			@(negedge d_clk);
			waited++;
		end
		if (link_up !== 1'b1) begin
			$display("Timeout: link_up did not rise within %0d cycles", LINK_TIMEOUT);
			step_errs++;
		end
	endtask

	// High phases too short to debounce, drops long enough to pass the chains
	task automatic run_glitches(input logic [STATUS_W-1:0] base, input int reps);
		int high_len;
		int drop_len;
		int lock_bits[3];
		int pick;
		lock_bits[0] = STATUS_PLL;
		lock_bits[1] = STATUS_CDR;
		lock_bits[2] = STATUS_SIGDET;
		for (int n = 0; n < reps; n++) begin
			high_len = SYNC_LEN + 2 + ({$random(seed)} % (STABLE_CYCLES - SYNC_LEN - 5));
			drop_len = SYNC_LEN + 3 + ({$random(seed)} % (STABLE_CYCLES - SYNC_LEN - 3));
			pick     = {$random(seed)} % 3;
			xcvr_status = base;
			watch_link_down(high_len);
			xcvr_status = base & ~(4'b0001 << lock_bits[pick]);
			watch_link_down(drop_len);
		end
	endtask

	// One FIFO error pulse per repeat, equal high and low phases
	task automatic send_fifo_pulses(input logic [STATUS_W-1:0] base, input int phase,
		input int reps);
		for (int n = 0; n < reps; n++) begin
			xcvr_status = base | (4'b0001 << STATUS_FIFO_ERR);
			wait_cycles(phase);
			xcvr_status = base & ~(4'b0001 << STATUS_FIFO_ERR);
			wait_cycles(phase);
		end
	endtask

	task automatic check_outputs(input logic [1:0] exp_state, input logic exp_link,
		input logic [CNT_W-1:0] exp_loss, input logic [CNT_W-1:0] exp_err);
		assert (link_up === exp_link)
			else begin
				$display("Mismatch link_up: got %h, expected %h", link_up, exp_link);
				step_errs++;
			end
		assert (link_state === exp_state)
			else begin
				$display("Mismatch link_state: got %h, expected %h", link_state, exp_state);
				step_errs++;
			end
		assert (loss_count === exp_loss)
			else begin
				$display("Mismatch loss_count: got %h, expected %h", loss_count, exp_loss);
				step_errs++;
			end
		assert (err_count === exp_err)
			else begin
				$display("Mismatch err_count: got %h, expected %h", err_count, exp_err);
				step_errs++;
			end
	endtask

	task automatic run_step(input string tag, input string op,
		input logic [STATUS_W-1:0] status, input int hold, input int reps,
		input logic [1:0] exp_state, input logic exp_link,
		input logic [CNT_W-1:0] exp_loss, input logic [CNT_W-1:0] exp_err);
		string verdict;
		step_errs = 0;
		if (op == "hold") begin
			xcvr_status = status;
			wait_cycles(hold);
			check_outputs(exp_state, exp_link, exp_loss, exp_err);
		end else if (op == "up") begin
			xcvr_status = status;
			wait_link_up();
			wait_cycles(hold);
			check_outputs(exp_state, exp_link, exp_loss, exp_err);
		end else if (op == "glitch") begin
			run_glitches(status, reps);
			xcvr_status = '0;
			wait_cycles(hold);
			check_outputs(exp_state, exp_link, exp_loss, exp_err);
		end else if (op == "pulse") begin
			send_fifo_pulses(status, hold, reps);
			check_outputs(exp_state, exp_link, exp_loss, exp_err);
		end else if (op == "reset") begin
			// Outputs checked while clr_n is still low
			xcvr_status = status;
			clr_n = 1'b0;
			wait_cycles(hold);
			check_outputs(exp_state, exp_link, exp_loss, exp_err);
			clr_n = 1'b1;
			wait_cycles(SETTLE_CYCLES);
		end else begin
			$display("Unknown step type %s in test %s", op, tag);
			step_errs++;
		end
		tests_run++;
		if (step_errs == 0) begin
			verdict = "ok";
		end else begin
			verdict = "FAILED";
			tests_failed++;
		end
		$display("Test %s (%s): %s", tag, op, verdict);
	endtask

	// Lines starting with # are skipped
	task automatic read_golden();
		string               tag;
		string               op;
		string               rest;
		logic [STATUS_W-1:0] status;
		int                  hold;
		int                  reps;
		int                  code;
		int                  lines;
		logic [1:0]          exp_state;
		logic                exp_link;
		logic [CNT_W-1:0]    exp_loss;
		logic [CNT_W-1:0]    exp_err;
		lines = 0;
		while (lines < MAX_LINES) begin
			code = $fscanf(fd, "%s", tag);
			if (code != 1) begin
				break;
			end
			lines++;
			if (tag.getc(0) == "#") begin
				code = $fgets(rest, fd);
			end else begin
				code = $fscanf(fd, "%s %h %d %d %h %h %h %h", op, status, hold, reps,
					exp_state, exp_link, exp_loss, exp_err);
				if (code != 8) begin
					$display("Golden line for test %s is incomplete", tag);
					tests_run++;
					tests_failed++;
					break;
				end
				run_step(tag, op, status, hold, reps, exp_state, exp_link, exp_loss, exp_err);
			end
		end
	endtask

	initial begin
		d_clk        = 1'b0;
		clr_n        = 1'b0;
		xcvr_status  = '0;
		seed         = 32'h2ae70a9e;
		step_errs    = 0;
		tests_run    = 0;
		tests_failed = 0;
		// Power-up reset, 10 cycles
		wait_cycles(10);
		clr_n = 1'b1;
		wait_cycles(SETTLE_CYCLES);
		fd = $fopen("testbench/status_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open testbench/status_golden.txt");
			tests_failed++;
		end else begin
			read_golden();
			$fclose(fd);
		end
		$display("Tests run %0d, passed %0d, failed %0d", tests_run,
			tests_run - tests_failed, tests_failed);
		if (tests_failed == 0 && tests_run > 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
common/xcvr_status_pkg.sv
common/xcvr_status_if.sv
verilog/reset_sync.sv
resync/status_resync.sv
verilog/link_monitor.sv
verilog/xcvr_status_top.sv
testbench/tb_xcvr_status.sv

// File: verilog/link_monitor.sv
// Link up debounce over pll, cdr and signal detect, plus loss and FIFO error counters
// Counters saturate at all ones and clear only on reset
// With INIT_VALUE 1 a fifo_err still high after reset counts as one error
`timescale 1ns/1ps
`default_nettype none

module link_monitor #(
	parameter int STABLE_CYCLES = 16
) (
	input  logic                                d_clk,
	input  logic                                rst_n,
	xcvr_status_if.dst                          status,
	output logic                                link_up,
	output xcvr_status_pkg::link_state_e        link_state,
	output logic [xcvr_status_pkg::CNT_W-1:0]   loss_count,
	output logic [xcvr_status_pkg::CNT_W-1:0]   err_count
);
	import xcvr_status_pkg::*;

	// Debounce counter, counts 0 .. STABLE_CYCLES-1 inside LINK_WAIT
	localparam int STAB_W = (STABLE_CYCLES > 1) ? $clog2(STABLE_CYCLES) : 1;
	localparam logic [STAB_W-1:0] STAB_LAST = STAB_W'(STABLE_CYCLES - 1);

	link_state_e       state;
	logic [STAB_W-1:0] stab_cnt;
	logic              lock_ok;
	logic              loss_event;
	logic              fifo_err_q;
	logic              err_rise;

	if (STABLE_CYCLES < 1) begin : g_stable_check
		$error("link_monitor needs STABLE_CYCLES >= 1, got %0d", STABLE_CYCLES);
	end

	// All three lock conditions together
	assign lock_ok = status.pll_locked & status.cdr_locked & status.sig_det;

	// Only a drop from LINK_UP is a loss, WAIT drops just restart
	assign loss_event = (state == LINK_UP) && !lock_ok;

	// One count per rising edge of the synchronized level
	assign err_rise = status.fifo_err & ~fifo_err_q;

	always_ff @(posedge d_clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= LINK_DOWN;
			stab_cnt <= '0;
		end else begin
			case (state)
				LINK_DOWN: begin
					stab_cnt <= '0;
					if (lock_ok) begin
						state <= LINK_WAIT;
					end
				end
				LINK_WAIT: begin
					if (!lock_ok) begin
						state <= LINK_DOWN;
					end else if (stab_cnt == STAB_LAST) begin
						// STABLE_CYCLES cycles of lock seen in WAIT
						state <= LINK_UP;
					end else begin
						stab_cnt <= stab_cnt + 1'b1;
					end
				end
				LINK_UP: begin
					if (!lock_ok) begin
						state <= LINK_DOWN;
					end
				end
				default: begin
					state <= LINK_DOWN;
				end
			endcase
		end
	end

	// Loss counter, stops at all ones
	always_ff @(posedge d_clk or negedge rst_n) begin
		if (!rst_n) begin
			loss_count <= '0;
		end else if (loss_event && !(&loss_count)) begin
			loss_count <= loss_count + 1'b1;
		end
	end

	// FIFO error edge detect and counter
	always_ff @(posedge d_clk or negedge rst_n) begin
		if (!rst_n) begin
			fifo_err_q <= 1'b0;
			err_count  <= '0;
		end else begin
			fifo_err_q <= status.fifo_err;
			if (err_rise && !(&err_count)) begin
				err_count <= err_count + 1'b1;
			end
		end
	end

	assign link_state = state;
	assign link_up    = (state == LINK_UP);

	// Link up only ever entered out of the debounce window
	assert property (@(posedge d_clk) disable iff (!rst_n)
		$rose(link_up) |-> (link_state == LINK_UP) && ($past(state) == LINK_WAIT))
		else $error("link_up rose without passing through LINK_WAIT");

	// Saturation, no wrap from all ones back to zero
	assert property (@(posedge d_clk) disable iff (!rst_n)
		(&$past(loss_count)) |-> (&loss_count))
		else $error("loss_count wrapped");
	assert property (@(posedge d_clk) disable iff (!rst_n)
		(&$past(err_count)) |-> (&err_count))
		else $error("err_count wrapped");

endmodule

`default_nettype wire

// File: verilog/reset_sync.sv
// Reset bridge for d_clk: asserts with clr_n at once, releases on the second edge
// clr_n must be held low long enough for at least one d_clk edge when d_clk is running
`timescale 1ns/1ps
`default_nettype none

module reset_sync (
	input  logic d_clk,
	input  logic clr_n,
	output logic rst_n
);

	// First stage, may go metastable on release
	logic meta_q;

	// Both stages cleared directly by clr_n
	always_ff @(posedge d_clk or negedge clr_n) begin
		if (!clr_n) begin
			meta_q <= 1'b0;
			rst_n  <= 1'b0;
		end else begin
			// Shift a one through, two edges to release
			meta_q <= 1'b1;
			rst_n  <= meta_q;
		end
	end

	// Internal reset never released while the external one is held
	assert property (@(posedge d_clk) !clr_n |-> !rst_n)
		else $error("rst_n high while clr_n low");

endmodule

`default_nettype wire

// File: verilog/xcvr_status_top.sv
// Transceiver status synchronizer and link monitor, RTL top level
// xcvr_status is asynchronous to d_clk; each level must last over one d_clk period
`timescale 1ns/1ps
`default_nettype none

module xcvr_status_top #(
	parameter int SYNC_LEN      = 3,
	parameter int INIT_VALUE    = 0,
	parameter int STABLE_CYCLES = 16
) (
	input  logic                                 d_clk,
	input  logic                                 clr_n,
	input  logic [xcvr_status_pkg::STATUS_W-1:0] xcvr_status,
	output logic                                 link_up,
	output logic [1:0]                           link_state,
	output logic [xcvr_status_pkg::CNT_W-1:0]    loss_count,
	output logic [xcvr_status_pkg::CNT_W-1:0]    err_count
);

	// Internal reset, released in step with d_clk
	logic rst_n;

	// Synchronized status levels
	xcvr_status_if status_if ();

	reset_sync reset_sync_i (
		.d_clk (d_clk),
		.clr_n (clr_n),
		.rst_n (rst_n)
	);

	// Metastability chains into d_clk
	status_resync #(
		.SYNC_LEN   (SYNC_LEN),
		.INIT_VALUE (INIT_VALUE)
	) status_resync_i (
		.d_clk     (d_clk),
		.rst_n     (rst_n),
		.status_in (xcvr_status),
		.sync_out  (status_if)
	);

	// Debounce and event counting
	link_monitor #(
		.STABLE_CYCLES (STABLE_CYCLES)
	) link_monitor_i (
		.d_clk      (d_clk),
		.rst_n      (rst_n),
		.status     (status_if),
		.link_up    (link_up),
		.link_state (link_state),
		.loss_count (loss_count),
		.err_count  (err_count)
	);

endmodule

`default_nettype wire
